/* sdmac_pkg.sv */
// SCSI DMA front end shared definitions
// Bus widths, address map, packed records and FSM states
package sdmac_pkg;

    // Bus widths
    localparam int CPU_ADDR_W  = 5;   // Longword address bits 6:2
    localparam int CPU_DATA_W  = 32;
    localparam int PORT_DATA_W = 16;
    localparam int STROBE_CNT_W = 4;  // Enough for the longest strobe

    typedef logic [CPU_ADDR_W-1:0]   cpu_addr_t;
    typedef logic [CPU_DATA_W-1:0]   cpu_word_t;
    typedef logic [PORT_DATA_W-1:0]  port_word_t;
    typedef logic [1:0]              dsack_t;      // Active low, dynamic size
    typedef logic [1:0]              reg_sel_t;    // Register index
    typedef logic [1:0]              dev_sel_t;    // Port device index
    typedef logic [STROBE_CNT_W-1:0] strobe_cnt_t;

    // Address map, bit positions inside cpu_addr_t
    localparam int PORT_SEL_BIT = 4;  // Addr bit 6, high selects the port
    localparam int DEV_SEL_LSB  = 2;  // Addr bits 5:4
    localparam int REG_SEL_LSB  = 0;  // Addr bits 3:2

    // Register half
    localparam reg_sel_t REG_CNTR = 2'd0;  // Control
    localparam reg_sel_t REG_ACR  = 2'd1;  // DMA address
    localparam reg_sel_t REG_WTC  = 2'd2;  // Word count
    localparam reg_sel_t REG_ISTR = 2'd3;  // Interrupt status, read only

    // ISTR bit layout
    localparam int ISTR_INTA_BIT   = 0;
    localparam int ISTR_INTB_BIT   = 1;
    localparam int ISTR_INT_EN_BIT = 2;

    // Port devices
    localparam dev_sel_t DEV_CSS  = 2'b00;  // SCSI controller
    localparam dev_sel_t DEV_CSX0 = 2'b01;
    localparam dev_sel_t DEV_CSX1 = 2'b10;

    // Acknowledge codes
    localparam dsack_t DSACK_32   = 2'b00;
    localparam dsack_t DSACK_16   = 2'b01;
    localparam dsack_t DSACK_NONE = 2'b11;

    // Strobe width in sclk cycles
    localparam int DEFAULT_STROBE_CYCLES = 4;
    localparam int STROBE_CYCLES_MIN     = 2;
    localparam int STROBE_CYCLES_MAX     = 15;

    typedef struct packed {
        logic       int_en;    // Gates int_n
        logic       dma_dir;   // Kept for software, no DMA engine here
        logic [5:0] reserved;
    } cntr_t;

    typedef struct packed {
        cpu_addr_t addr;
        logic      r_w;        // High for read
        cpu_word_t wdata;
    } cpu_req_t;

    typedef struct packed {
        logic css_n;
        logic csx0_n;
        logic csx1_n;
    } port_cs_t;

    localparam port_cs_t CS_IDLE = 3'b111;  // No device selected

    typedef enum logic [2:0] {
        IDLE,
        REG_ACCESS,
        PORT_SETUP,
        PORT_STROBE,
        ACK,
        RELEASE
    } bus_state_t;

endpackage

/* strobe_timer.sv */
// Peripheral strobe timer
// Counts the programmed strobe width and stalls while the device holds iordy low
`timescale 1ns/1ps

module strobe_timer #(
    parameter int STROBE_CYCLES = sdmac_pkg::DEFAULT_STROBE_CYCLES
) (
    input  logic sclk,
    input  logic reset,
    input  logic timer_start,
    input  logic iordy,
    output logic timer_done
);
    import sdmac_pkg::*;

    localparam strobe_cnt_t LOAD = strobe_cnt_t'(STROBE_CYCLES - 1);  // Zero is the last cycle

    if ((STROBE_CYCLES < STROBE_CYCLES_MIN) || (STROBE_CYCLES > STROBE_CYCLES_MAX)) begin : g_range
        $error("STROBE_CYCLES out of range");
    end

    strobe_cnt_t count;
    logic        busy;

    // Done only on the final count with the device ready
    assign timer_done = busy && iordy && (count == '0);

    always_ff @(posedge sclk) begin
        if (reset) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (timer_start) begin
            busy  <= 1'b1;
            count <= LOAD;
        end else if (busy && iordy) begin  // Hold while iordy low
            if (count == '0) begin
                busy <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* bus_cycle_fsm.sv */
// CPU bus cycle controller
// Latches each cycle, steers it to registers or port and returns dsack_n
`timescale 1ns/1ps

module bus_cycle_fsm (
    input  logic                  sclk,
    input  logic                  reset,
    input  logic                  cs_n,
    input  logic                  as_n,
    input  logic                  ds_n,
    input  logic                  r_w,
    input  sdmac_pkg::cpu_addr_t  addr,
    input  sdmac_pkg::cpu_word_t  data_in,
    input  logic                  timer_done,
    output sdmac_pkg::cpu_req_t   req,
    output logic                  reg_strobe,
    output logic                  timer_start,
    output logic                  port_active,
    output logic                  strobe_phase,
    output sdmac_pkg::dsack_t     dsack_n,
    output logic                  data_oe
);
    import sdmac_pkg::*;

    bus_state_t state;
    bus_state_t state_next;
    logic       cycle_start;
    logic       port_cycle;    // Latched cycle targets the port
    logic       ack_next;

    assign cycle_start = (state == IDLE) && !cs_n && !as_n && !ds_n;
    assign port_cycle  = req.addr[PORT_SEL_BIT];

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (cycle_start) begin
                    state_next = addr[PORT_SEL_BIT] ? PORT_SETUP : REG_ACCESS;
                end
            end
            REG_ACCESS:  state_next = ACK;     // Read data registered here
            PORT_SETUP:  state_next = PORT_STROBE;
            PORT_STROBE: if (timer_done) state_next = ACK;
            ACK:         if (as_n) state_next = RELEASE;  // CPU holds as_n to stall
            RELEASE:     state_next = IDLE;
            default:     state_next = IDLE;
        endcase
    end

    assign ack_next = (state_next == ACK);

    // Single cycle pulses to the datapath blocks
    assign reg_strobe  = (state == REG_ACCESS);
    assign timer_start = (state == PORT_SETUP);
    // Strobe asked for from setup until the timer ends
    assign strobe_phase = (state == PORT_SETUP) ||
                          ((state == PORT_STROBE) && !timer_done);

    always_ff @(posedge sclk) begin
        if (reset) begin
            state       <= IDLE;
            dsack_n     <= DSACK_NONE;
            data_oe     <= 1'b0;
            port_active <= 1'b0;
        end else begin
            state   <= state_next;
            dsack_n <= DSACK_NONE;
            if (ack_next) begin
                dsack_n <= port_cycle ? DSACK_16 : DSACK_32;  // Sized by target
            end
            data_oe     <= ack_next && req.r_w;    // Drive CPU data on reads only
            port_active <= (state_next == PORT_SETUP) ||
                           (state_next == PORT_STROBE) ||
                           (ack_next && port_cycle);
        end
    end

    // Request payload, taken once per cycle
    always_ff @(posedge sclk) begin
        if (cycle_start) begin
            req.addr  <= addr;
            req.r_w   <= r_w;
            req.wdata <= data_in;   // Write data valid with ds_n
        end
    end

endmodule

/* sdmac_registers.sv */
// Internal register file
// Control, DMA address, word count and interrupt status with gated interrupt
`timescale 1ns/1ps

module sdmac_registers (
    input  logic                  sclk,
    input  logic                  reset,
    input  logic                  reg_strobe,
    input  sdmac_pkg::cpu_req_t   req,
    input  logic                  inta,
    input  logic                  intb,
    output sdmac_pkg::cpu_word_t  reg_rdata,
    output logic                  int_n
);
    import sdmac_pkg::*;

    cntr_t     cntr;
    cpu_word_t acr;
    cpu_word_t wtc;
    cpu_word_t istr;
    reg_sel_t  reg_sel;
    logic      reg_write;

    assign reg_sel   = req.addr[REG_SEL_LSB +: $bits(reg_sel_t)];
    assign reg_write = reg_strobe && !req.r_w;

    // Status is live, never stored
    always_comb begin
        istr                  = '0;
        istr[ISTR_INTA_BIT]   = inta;     // SCSI controller
        istr[ISTR_INTB_BIT]   = intb;     // Spare source
        istr[ISTR_INT_EN_BIT] = cntr.int_en;
    end

    always_ff @(posedge sclk) begin
        if (reset) begin
            cntr <= '0;
            acr  <= '0;
            wtc  <= '0;
        end else if (reg_write) begin
            case (reg_sel)
                REG_CNTR: cntr <= req.wdata[$bits(cntr_t)-1:0];  // Low byte only
                REG_ACR:  acr  <= req.wdata;
                REG_WTC:  wtc  <= req.wdata;
                default:  ;                    // ISTR is read only
            endcase
        end
    end

    // Read data ready for the ACK state
    always_ff @(posedge sclk) begin
        if (reg_strobe) begin
            case (reg_sel)
                REG_CNTR: reg_rdata <= cpu_word_t'(cntr);  // Zero extended
                REG_ACR:  reg_rdata <= acr;
                REG_WTC:  reg_rdata <= wtc;
                default:  reg_rdata <= istr;
            endcase
        end
    end

    // Interrupt to the CPU
    always_ff @(posedge sclk) begin
        if (reset) begin
            int_n <= 1'b1;
        end else begin
            int_n <= !(cntr.int_en && (inta || intb));  // Low when enabled and pending
        end
    end

endmodule

/* port_datapath.sv */
// Peripheral port datapath
// Chip select decode, timed read and write strobes, port data in and out
`timescale 1ns/1ps

module port_datapath (
    input  logic                  sclk,
    input  logic                  reset,
    input  sdmac_pkg::cpu_req_t   req,
    input  logic                  port_active,
    input  logic                  strobe_phase,
    input  logic                  timer_done,
    input  sdmac_pkg::port_word_t pd_in,
    output sdmac_pkg::port_word_t pd_out,
    output logic                  pd_oe,
    output sdmac_pkg::port_cs_t   port_cs,
    output logic                  ior_n,
    output logic                  iow_n,
    output sdmac_pkg::cpu_word_t  port_rdata
);
    import sdmac_pkg::*;

    dev_sel_t   dev_sel;
    port_cs_t   cs_decode;
    port_word_t rd_capture;

    assign dev_sel = req.addr[DEV_SEL_LSB +: $bits(dev_sel_t)];

    always_comb begin
        cs_decode = CS_IDLE;
        case (dev_sel)
            DEV_CSS:  cs_decode.css_n  = 1'b0;
            DEV_CSX0: cs_decode.csx0_n = 1'b0;
            DEV_CSX1: cs_decode.csx1_n = 1'b0;
            default:  ;                          // Unused slot still acknowledged
        endcase
    end

    assign port_cs = port_active ? cs_decode : CS_IDLE;  // Held through ACK

    // Upper CPU half goes to the 16 bit port
    assign pd_out = req.wdata[CPU_DATA_W-1 -: PORT_DATA_W];
    assign pd_oe  = port_active && !req.r_w;

    always_ff @(posedge sclk) begin
        if (reset) begin
            ior_n <= 1'b1;
            iow_n <= 1'b1;
        end else begin
            ior_n <= !(strobe_phase && req.r_w);
            iow_n <= !(strobe_phase && !req.r_w);
        end
    end

    // Sample device data while the strobe is still low
    always_ff @(posedge sclk) begin
        if (timer_done && req.r_w) begin
            rd_capture <= pd_in;
        end
    end

    assign port_rdata = {rd_capture, rd_capture};  // Both halves for 16 bit port

endmodule

/* resdmac.sv */
// SCSI DMA controller front end
// CPU bus cycles to the register file or the 16 bit peripheral port
`timescale 1ns/1ps

module resdmac #(
    parameter int STROBE_CYCLES = sdmac_pkg::DEFAULT_STROBE_CYCLES
) (
    input  logic                  sclk,
    input  logic                  reset,
    input  logic                  cs_n,
    input  logic                  as_n,
    input  logic                  ds_n,
    input  logic                  r_w,
    input  sdmac_pkg::cpu_addr_t  addr,
    input  sdmac_pkg::cpu_word_t  data_in,
    output sdmac_pkg::cpu_word_t  data_out,
    output logic                  data_oe,
    output sdmac_pkg::dsack_t     dsack_n,
    output logic                  int_n,
    input  logic                  inta,
    input  logic                  intb,
    input  logic                  iordy,
    output sdmac_pkg::port_cs_t   port_cs,
    output logic                  ior_n,
    output logic                  iow_n,
    input  sdmac_pkg::port_word_t pd_in,
    output sdmac_pkg::port_word_t pd_out,
    output logic                  pd_oe,
    output logic                  led_rd_n,
    output logic                  led_wr_n
);
    import sdmac_pkg::*;

    cpu_req_t  req;
    cpu_word_t reg_rdata;
    cpu_word_t port_rdata;
    logic      reg_strobe;
    logic      timer_start;
    logic      timer_done;
    logic      port_active;
    logic      strobe_phase;

    bus_cycle_fsm u_bus_cycle_fsm (
        .sclk, .reset,
        .cs_n, .as_n, .ds_n, .r_w,
        .addr, .data_in,
        .timer_done,
        .req, .reg_strobe, .timer_start, .port_active, .strobe_phase,
        .dsack_n, .data_oe
    );

    strobe_timer #(.STROBE_CYCLES(STROBE_CYCLES)) u_strobe_timer (
        .sclk, .reset,
        .timer_start, .iordy,
        .timer_done
    );

    sdmac_registers u_sdmac_registers (
        .sclk, .reset,
        .reg_strobe, .req,
        .inta, .intb,
        .reg_rdata, .int_n
    );

    port_datapath u_port_datapath (
        .sclk, .reset,
        .req, .port_active, .strobe_phase, .timer_done,
        .pd_in, .pd_out, .pd_oe,
        .port_cs, .ior_n, .iow_n,
        .port_rdata
    );

    // Latched addr bit 6 picks the source
    assign data_out = req.addr[PORT_SEL_BIT] ? port_rdata : reg_rdata;

    // Activity LEDs straight from the bus
    assign led_wr_n = r_w || cs_n;
    assign led_rd_n = !r_w || cs_n;

endmodule

/* resdmac_properties.sv */
// Bus protocol checks for the SCSI DMA front end
// Strobe, chip select and acknowledge rules, bound into resdmac
`timescale 1ns/1ps

module resdmac_properties (
    input logic                sclk,
    input logic                reset,
    input logic                as_n,
    input logic                ior_n,
    input logic                iow_n,
    input sdmac_pkg::port_cs_t port_cs,
    input sdmac_pkg::dsack_t   dsack_n
);
    import sdmac_pkg::*;

    logic [2:0] cs_bits;
    assign cs_bits = port_cs;

    a_one_strobe: assert property (@(posedge sclk) disable iff (reset) (ior_n || iow_n))
        else $error("ior_n and iow_n both low");
    a_one_select: assert property (@(posedge sclk) disable iff (reset) $countones(~cs_bits) <= 1)
        else $error("more than one chip select low");
    a_dsack_code: assert property (@(posedge sclk) disable iff (reset) dsack_n != 2'b10)
        else $error("illegal dsack_n code 10");
    // Acknowledge drops one edge after the CPU lets go of as_n
    a_release: assert property (@(posedge sclk) disable iff (reset)
        ((dsack_n != DSACK_NONE) && as_n) |=> (dsack_n == DSACK_NONE))
        else $error("dsack_n still asserted after as_n release");

endmodule

bind resdmac resdmac_properties u_resdmac_properties (.*);

/* tb_resdmac.sv */
// Testbench for the SCSI DMA front end
// Directed register, port, stretch and release cycles against a small device model
`timescale 1ns/1ps

module tb_resdmac;
    import sdmac_pkg::*;

    localparam int STROBE    = 4;
    localparam int MAX_STALL = 8;                       // 1 + three LFSR bits
    localparam int WORST     = STROBE + MAX_STALL + 4;  // Longest cycle in sclk
    localparam longint WATCHDOG_NS = 6 * 64 * WORST * 20;

    logic       sclk;
    logic       reset;
    logic       cs_n;
    logic       as_n;
    logic       ds_n;
    logic       r_w;
    cpu_addr_t  addr;
    cpu_word_t  data_in;
    cpu_word_t  data_out;
    logic       data_oe;
    dsack_t     dsack_n;
    logic       int_n;
    logic       inta;
    logic       intb;
    logic       iordy;
    port_cs_t   port_cs;
    logic       ior_n;
    logic       iow_n;
    port_word_t pd_in;
    port_word_t pd_out;
    logic       pd_oe;
    logic       led_rd_n;
    logic       led_wr_n;

    logic [31:0] lfsr;
    int          errors;
    int          test_errors;
    int          tests;
    port_word_t  dev_wdata;       // Last word seen by the device
    port_word_t  dev_rdata;       // Word the device returns
    cpu_word_t   last_rdata;
    dsack_t      last_ack;
    port_cs_t    last_cs;
    int          ack_cycles;      // Rising edges from cycle start to dsack_n, start edge included
    int          iow_low;
    int          ior_low;

    resdmac #(.STROBE_CYCLES(STROBE)) u_resdmac (.*);

    initial begin
        sclk = 1'b0;
        forever #10 sclk = ~sclk;
    end

    // Device model
    always @(posedge iow_n) dev_wdata = pd_out;                 // Write lands at strobe end
    always @(negedge sclk) pd_in <= ior_n ? 16'h0000 : dev_rdata;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);  // Galois taps
        end
        return r;
    endfunction

    function automatic cpu_addr_t reg_addr(input reg_sel_t r);
        return {3'b000, r};
    endfunction

    function automatic cpu_addr_t port_addr(input logic [1:0] dev);
        return {1'b1, dev, 2'b00};    // Addr bit 6 high, device in bits 5:4
    endfunction

    task automatic check_word(input string name, input cpu_word_t got, input cpu_word_t exp);
        if (got !== exp) begin
            test_errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_port(input string name, input port_word_t got, input port_word_t exp);
        if (got !== exp) begin
            test_errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_dsack(input string name, input dsack_t got, input dsack_t exp);
        if (got !== exp) begin
            test_errors++;
            $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_cs(input string name, input port_cs_t got, input port_cs_t exp);
        if (got !== exp) begin
            test_errors++;
            $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            test_errors++;
            $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_cycles(input string name, input int got, input int exp);
        if (got != exp) begin
            test_errors++;
            $display("[FAIL] %0t %s: got %0d cycles, expected %0d", $time, name, got, exp);
        end
    endtask

    // One full CPU cycle, called and left on a falling edge with the FSM idle
    task automatic run_cycle(input cpu_addr_t a, input logic rd, input cpu_word_t wdata,
                             input int hold);
        int n;
        n       = 0;
        iow_low = 0;
        ior_low = 0;
        addr    = a;
        r_w     = rd;
        data_in = wdata;
        cs_n    = 1'b0;
        as_n    = 1'b0;
        ds_n    = 1'b0;
        do begin
            @(negedge sclk);
            n++;
            if (n == 1) begin
                last_cs = port_cs;              // Select follows the start edge
                check_bit("pd_oe at setup", pd_oe, a[PORT_SEL_BIT] && !rd);  // Port writes only
            end
            iow_low += !iow_n;
            ior_low += !ior_n;
        end while ((dsack_n === DSACK_NONE) && (n < 4 * WORST));
        if (dsack_n === DSACK_NONE) begin
            test_errors++;
            $display("%0t: no acknowledge after %0d cycles at address %h", $time, n, a);
        end
        ack_cycles = n;
        last_ack   = dsack_n;
        last_rdata = data_out;
        check_bit("data_oe", data_oe, rd);      // CPU data driven on reads only
        check_bit("pd_oe at ack", pd_oe, a[PORT_SEL_BIT] && !rd);
        check_bit("led_rd_n", led_rd_n, !rd);
        check_bit("led_wr_n", led_wr_n, rd);
        repeat (hold) begin
            @(negedge sclk);
            check_dsack("dsack_n held", dsack_n, last_ack);
        end
        cs_n = 1'b1;
        as_n = 1'b1;
        ds_n = 1'b1;
        @(negedge sclk);
        check_dsack("dsack_n release", dsack_n, DSACK_NONE);
        check_bit("pd_oe release", pd_oe, 1'b0);
        @(negedge sclk);                        // RELEASE back to IDLE
    endtask

    task automatic cpu_write(input cpu_addr_t a, input cpu_word_t wdata, input int hold);
        run_cycle(a, 1'b0, wdata, hold);
    endtask

    task automatic cpu_read(input cpu_addr_t a, input int hold);
        run_cycle(a, 1'b1, '0, hold);
    endtask

    task automatic finish_test(input string name);
        tests++;
        errors += test_errors;
        if (test_errors == 0) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic test_registers();
        cpu_word_t acr_v;
        cpu_word_t wtc_v;
        cpu_word_t cntr_v;
        acr_v  = rand_bits(32);
        wtc_v  = rand_bits(32);
        cntr_v = rand_bits(32);
        cpu_write(reg_addr(REG_ACR), acr_v, 0);
        check_dsack("dsack_n ACR write", last_ack, DSACK_32);
        check_cycles("register acknowledge", ack_cycles, 2);   // Second rising edge of the cycle
        cpu_write(reg_addr(REG_WTC), wtc_v, 0);
        cpu_write(reg_addr(REG_CNTR), cntr_v, 0);
        cpu_read(reg_addr(REG_ACR), 0);
        check_word("ACR", last_rdata, acr_v);
        check_cycles("register acknowledge", ack_cycles, 2);
        cpu_read(reg_addr(REG_WTC), 0);
        check_word("WTC", last_rdata, wtc_v);
        cpu_read(reg_addr(REG_CNTR), 0);
        check_word("CNTR", last_rdata, {24'd0, cntr_v[7:0]});  // Byte wide register
        check_dsack("dsack_n CNTR read", last_ack, DSACK_32);
        finish_test("register write and read-back");
    endtask

    task automatic test_interrupts();
        cpu_word_t exp;
        for (int en = 0; en < 2; en++) begin
            cpu_write(reg_addr(REG_CNTR), {24'd0, en[0], 7'd0}, 0);  // int_en is bit 7
            for (int k = 0; k < 4; k++) begin
                inta = k[0];
                intb = k[1];
                @(negedge sclk);
                check_bit("int_n", int_n, !(en[0] && (k != 0)));   // One edge later
                exp = {29'd0, en[0], k[1], k[0]};
                cpu_read(reg_addr(REG_ISTR), 0);
                check_word("ISTR", last_rdata, exp);
            end
        end
        cpu_write(reg_addr(REG_ISTR), 32'hffff_ffff, 0);        // Read only
        cpu_read(reg_addr(REG_ISTR), 0);
        check_word("ISTR after write", last_rdata, exp);
        cpu_read(reg_addr(REG_CNTR), 0);
        check_word("CNTR after ISTR write", last_rdata, 32'h0000_0080);
        inta = 1'b0;
        intb = 1'b0;
        finish_test("interrupt status and gating");
    endtask

    task automatic test_port_write();
        cpu_word_t wdata;
        port_cs_t  exp_cs;
        for (int d = 0; d < 4; d++) begin
            wdata  = rand_bits(32);
            exp_cs = port_cs_t'(~(3'b100 >> d));    // Code 11 selects nothing
            cpu_write(port_addr(d[1:0]), wdata, 0);
            check_cs("port_cs", last_cs, exp_cs);
            check_dsack("dsack_n port write", last_ack, DSACK_16);
            check_cycles("iow_n low", iow_low, STROBE);
            check_cycles("ior_n low", ior_low, 0);
            check_port("device write data", dev_wdata, wdata[31:16]);
        end
        finish_test("port write");
    endtask

    task automatic test_port_read();
        for (int d = 0; d < 3; d++) begin
            dev_rdata = rand_bits(16);
            cpu_read(port_addr(d[1:0]), 0);
            check_word("data_out port", last_rdata, {dev_rdata, dev_rdata});
            check_dsack("dsack_n port read", last_ack, DSACK_16);
            check_cycles("ior_n low", ior_low, STROBE);
            check_cycles("iow_n low", iow_low, 0);
        end
        finish_test("port read");
    endtask

    task automatic test_iordy_stretch();
        int stall;
        stall     = 1 + rand_bits(3);
        dev_rdata = rand_bits(16);
        iordy     = 1'b0;
        fork
            cpu_read(port_addr(2'b00), 0);
            begin
                do @(negedge sclk); while (ior_n === 1'b1);
                repeat (stall) begin
                    check_bit("ior_n stalled", ior_n, 1'b0);
                    check_dsack("dsack_n stalled", dsack_n, DSACK_NONE);
                    @(negedge sclk);
                end
                iordy = 1'b1;                   // Device ready, timer resumes
            end
        join
        check_cycles("stretched acknowledge", ack_cycles, STROBE + 2 + stall);
        check_cycles("stretched ior_n low", ior_low, STROBE + stall);
        check_word("data_out stretched", last_rdata, {dev_rdata, dev_rdata});
        finish_test("iordy stretch");
    endtask

    task automatic test_backpressure();
        int hold;
        hold = 2 + rand_bits(3);
        cpu_write(reg_addr(REG_WTC), rand_bits(32), hold);
        check_dsack("dsack_n held write", last_ack, DSACK_32);
        dev_rdata = rand_bits(16);
        cpu_read(port_addr(2'b01), hold);
        check_dsack("dsack_n held read", last_ack, DSACK_16);
        check_bit("led_rd_n idle", led_rd_n, 1'b1);
        check_bit("led_wr_n idle", led_wr_n, 1'b1);
        finish_test("back-pressure, release and LEDs");
    endtask

    initial begin
        lfsr        = 32'h3efc_bd60;
        errors      = 0;
        test_errors = 0;
        tests       = 0;
        reset       = 1'b1;
        cs_n        = 1'b1;
        as_n        = 1'b1;
        ds_n        = 1'b1;
        r_w         = 1'b1;
        addr        = '0;
        data_in     = '0;
        inta        = 1'b0;
        intb        = 1'b0;
        iordy       = 1'b1;
        pd_in       = '0;
        dev_rdata   = '0;
        repeat (10) @(negedge sclk);
        reset = 1'b0;
        @(negedge sclk);
        check_dsack("dsack_n after reset", dsack_n, DSACK_NONE);
        check_cs("port_cs after reset", port_cs, 3'b111);
        check_bit("int_n after reset", int_n, 1'b1);
        check_bit("pd_oe after reset", pd_oe, 1'b0);
        test_registers();
        test_interrupts();
        test_port_write();
        test_port_read();
        test_iordy_stretch();
        test_backpressure();
        $display("Tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t, a bus cycle never completed", $time);
        $display("Done: errors found");
        $finish;
    end

endmodule

/* list.f */
sdmac_pkg.sv
strobe_timer.sv
bus_cycle_fsm.sv
sdmac_registers.sv
port_datapath.sv
resdmac.sv
resdmac_properties.sv
tb_resdmac.sv

/* Bender.yml */
package:
  name: resdmac

sources:
  - sdmac_pkg.sv
  - strobe_timer.sv
  - bus_cycle_fsm.sv
  - sdmac_registers.sv
  - port_datapath.sv
  - resdmac.sv
  - target: test
    files:
      - resdmac_properties.sv
      - tb_resdmac.sv
